/* all.f */
verilog/gba_save_pkg.sv
verilog/cart_loader.sv
verilog/save_tracker.sv
verilog/backup_ctrl.sv
verilog/block_copier.sv
verilog/sector_buffer.sv
verilog/gba_save_top.sv
verification/clock_gen.sv
verification/gba_save_assertions.sv
verification/tb_gba_save.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_gba_save -o sim_gba_save \
	&& ./obj_dir/sim_gba_save > sim.log 2>&1 \
	|| echo "Simulation FAILED" >> sim.log

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* verification/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
	output logic clk_sys,
	output logic arst_n
);

	localparam int half_period = 20;   // 40 ns clock
	localparam int reset_cycles = 3;

	initial begin
		clk_sys = 1'b0;
		forever #(half_period) clk_sys = ~clk_sys;
	end

	// Reset held low for the first few edges
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

/* verification/gba_save_assertions.sv */
`timescale 1ns/1ps

module gba_save_assertions
	import gba_save_pkg::*;
(
	input logic     clk_sys,
	input logic     arst_n,
	input sd_req_t  sd,
	input bios_wr_t bios,
	input mem_req_t mem,
	input logic     bk_busy
);

	// ============================================================
	// SD side
	// ============================================================
	sd_one_dir: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd.rd && sd.wr))
		else $error("sd.rd and sd.wr high in the same cycle");

	// ============================================================
	// Strobes
	// ============================================================
	bios_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bios.wr |=> !bios.wr)
		else $error("bios.wr held longer than one cycle");

	mem_in_busy: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem.req |-> bk_busy)
		else $error("mem.req outside a load or save");   // Copier only runs inside a transfer

endmodule

bind gba_save_top gba_save_assertions gba_save_assertions_i (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.sd      (sd),
	.bios    (bios),
	.mem     (mem),
	.bk_busy (bk_busy)
);

/* verification/tb_gba_save.sv */
`timescale 1ns/1ps

module tb_gba_save
	import gba_save_pkg::*;
();

	typedef enum logic [2:0] {op_bios, op_cart, op_evt, op_img, op_save} op_t;

	typedef struct {
		op_t         op;
		logic [31:0] arg;        // Base address, strobe bits or image size
		logic        marker;     // Cart carries FLASH1M_V
		logic [7:0]  exp_sz;
		logic        exp_flag;   // flash_1m, bk_pending or bk_ena by op
	} step_t;

	localparam int n_steps       = 9;
	localparam int max_mem_delay = 3;   // 2 random bits
	localparam int max_sd_delay  = 7;   // 3 random bits

	step_t steps [n_steps] = '{
		'{op_bios, 32'h100,   1'b0, 8'h00, 1'b0},
		'{op_cart, 32'h0,     1'b1, 8'h00, 1'b1},   // Marker set, auto load
		'{op_evt,  32'hC,     1'b0, 8'h0F, 1'b1},   // Eeprom
		'{op_evt,  32'hA,     1'b0, 8'h3F, 1'b1},   // Sram
		'{op_evt,  32'h9,     1'b0, 8'hFF, 1'b1},   // Flash with 1M
		'{op_cart, 32'h2000,  1'b0, 8'h00, 1'b0},   // No marker
		'{op_img,  32'd8192,  1'b0, 8'd15, 1'b1},
		'{op_evt,  32'hA,     1'b0, 8'd15, 1'b1},   // Image size wins
		'{op_save, 32'h0,     1'b0, 8'd15, 1'b0}
	};

	logic        clk_sys;
	logic        arst_n;
	dl_port_t    dl;
	save_evt_t   save_evt;
	img_t        img;
	logic        load_req;
	logic        save_req;
	logic        sd_ack;
	logic [7:0]  sd_buff_addr;
	logic        sd_buff_wr;
	logic [15:0] sd_buff_dout;
	logic [15:0] sd_buff_din;
	logic        mem_ack;
	logic [15:0] mem_rdata;
	bios_wr_t    bios;
	logic [24:0] max_pak_addr;
	logic        flash_1m;
	logic        cart_busy;
	logic        bk_ena;
	logic        bk_pending;
	logic        bk_busy;
	sd_req_t     sd;
	mem_req_t    mem;

	logic [15:0] mem_model [0:65535];   // Backup memory
	logic [15:0] sd_img    [0:65535];   // Save file on the card
	logic [31:0] lfsr_state = 32'h846292e7;
	int          mem_cnt;
	int          sd_cnt;
	logic        exp_load;              // Direction of the running transfer
	bios_wr_t    bios_q [$];

	clock_gen clock_gen_i (.clk_sys(clk_sys), .arst_n(arst_n));

	gba_save_top gba_save_top_i (.*);

	// ============================================================
	// Random delays and error reporting
	// ============================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);   // One step per bit
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_bios(input bios_wr_t got, input bios_wr_t exp);
		if (got !== exp)
			report_mismatch($sformatf("bios addr %h data %h, expected addr %h data %h",
				got.addr, got.data, exp.addr, exp.data));
	endtask

	task automatic check_sz(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) report_mismatch($sformatf("save_sz %h, expected %h", got, exp));
	endtask

	task automatic check_mem(input mem_req_t got, input mem_req_t exp, input logic with_data);
		if (got.rnw !== exp.rnw || got.addr !== exp.addr || (with_data && got.wdata !== exp.wdata))
			report_mismatch($sformatf("mem rnw %b addr %h wdata %h, expected rnw %b addr %h wdata %h",
				got.rnw, got.addr, got.wdata, exp.rnw, exp.addr, exp.wdata));
	endtask

	task automatic check_sd(input sd_req_t got, input sd_req_t exp);
		if (got !== exp)
			report_mismatch($sformatf("sd rd %b wr %b lba %0d, expected rd %b wr %b lba %0d",
				got.rd, got.wr, got.lba, exp.rd, exp.wr, exp.lba));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_addr(input logic [24:0] got, input logic [24:0] exp);
		if (got !== exp) report_mismatch($sformatf("max_pak_addr %h, expected %h", got, exp));
	endtask

	task automatic check_word(input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) report_mismatch($sformatf("sd write data %h, expected %h", got, exp));
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) report_mismatch($sformatf("%s count %0d, expected %0d", what, got, exp));
	endtask

	// ============================================================
	// SD card and memory models
	// ============================================================
	initial begin : sd_model
		sd_req_t req_seen;
		int      base;
		int      d;
		wait (arst_n);
		forever begin
			@(posedge clk_sys);
			if (sd.rd | sd.wr) begin
				req_seen = sd;
				check_sd(req_seen, sd_req_t'{rd: exp_load, wr: ~exp_load, lba: sd_cnt[7:0]});
				base = int'(req_seen.lba) * 256;
				d = rand_bits(3);
				repeat (d) @(posedge clk_sys);
				sd_ack <= 1'b1;
				if (req_seen.rd) begin
					for (int i = 0; i < 256; i++) begin
						@(posedge clk_sys);
						sd_buff_addr <= i[7:0];
						sd_buff_wr   <= 1'b1;
						sd_buff_dout <= sd_img[base+i];
					end
					@(posedge clk_sys);
					sd_buff_wr <= 1'b0;
				end else begin
					// Buffer read has two edges of latency
					for (int i = 0; i < 258; i++) begin
						@(posedge clk_sys);
						if (i >= 2) begin
							check_word(sd_buff_din, mem_model[base+i-2]);
							sd_img[base+i-2] = sd_buff_din;
						end
						if (i < 256) sd_buff_addr <= i[7:0];
					end
				end
				@(posedge clk_sys);
				sd_ack <= 1'b0;   // Falling ack ends the sector
				sd_cnt++;
			end
		end
	end

	initial begin : mem_model_proc
		mem_req_t got;
		mem_req_t exp;
		int       d;
		wait (arst_n);
		forever begin
			@(posedge clk_sys);
			if (mem.req) begin
				got = mem;
				exp.req   = 1'b1;
				exp.rnw   = ~exp_load;
				exp.addr  = mem_cnt[15:0];   // Words go out in order
				exp.wdata = sd_img[mem_cnt[15:0]];
				check_mem(got, exp, exp_load);
				if (!got.rnw) mem_model[got.addr] = got.wdata;
				d = rand_bits(2);
				repeat (d) @(posedge clk_sys);
				mem_ack   <= 1'b1;
				mem_rdata <= mem_model[got.addr];
				@(posedge clk_sys);
				mem_ack <= 1'b0;
				mem_cnt++;
			end
		end
	end

	always @(posedge clk_sys) if (bios.wr) bios_q.push_back(bios);

	initial begin : watchdog
		longint unsigned cycles;
		cycles = n_steps * 500 + 3 * 256 * (256 * (max_mem_delay + 4) + max_sd_delay + 300);
		#(cycles * 40);
		abort_run("watchdog expired before the tests finished");
	end

	// ============================================================
	// Step tasks
	// ============================================================
	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic send_half(input logic [26:0] addr, input logic [15:0] half);
		@(posedge clk_sys);
		dl.wr        <= 1'b1;
		dl.addr      <= addr;
		dl.dout.half <= half;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
	endtask

	task automatic wait_backup();
		int n;
		n = 0;
		while (!bk_busy) begin
			@(posedge clk_sys);
			n++;
			if (n > 20) abort_run("backup sequencer did not start");
		end
		while (bk_busy) @(posedge clk_sys);   // Watchdog bounds this
	endtask

	task automatic run_bios(input logic [26:0] base);
		logic [15:0] h [4];
		logic [26:0] a;
		bios_wr_t    exp;
		for (int k = 0; k < 4; k++) h[k] = base[15:0] ^ (16'h1357 * 16'(k + 1));
		bios_q.delete();
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= bios_index;
		tick(2);
		check_flag("cart_busy", cart_busy, 1'b0);   // BIOS index is not a cart
		for (int k = 0; k < 4; k++) send_half(base + 27'(2 * k), h[k]);
		@(posedge clk_sys);
		dl.download <= 1'b0;
		tick(3);
		check_count("bios strobe", bios_q.size(), 2);
		for (int w = 0; w < 2; w++) begin
			a = base + 27'(4 * w);
			exp.wr   = 1'b1;
			exp.addr = a[13:2];
			exp.data = {h[2*w+1], h[2*w]};   // High half last
			check_bios(bios_q[w], exp);
		end
	endtask

	task automatic run_cart(input logic [26:0] base, input logic marker, input logic [7:0] sz);
		logic [7:0]  bytes [32];
		logic [26:0] last;
		for (int k = 0; k < 32; k++)
			bytes[k] = (marker && k >= 5 && k < 14) ? flash_marker[8*(13-k) +: 8] : 8'(8'h20 + k);
		exp_load = 1'b1;
		mem_cnt  = 0;
		sd_cnt   = 0;
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= 8'd1;
		tick(2);
		check_flag("cart_busy", cart_busy, 1'b1);
		for (int w = 0; w < 16; w++) send_half(base + 27'(2 * w), {bytes[2*w+1], bytes[2*w]});
		@(posedge clk_sys);
		dl.download <= 1'b0;
		wait_backup();   // Auto load of all sectors
		tick(2);
		last = base + 27'd30;
		check_flag("cart_busy", cart_busy, 1'b0);
		check_flag("flash_1m", flash_1m, marker);
		check_addr(max_pak_addr, last[26:2]);
		check_sz(gba_save_top_i.save_sz, sz);
		check_count("sd read", sd_cnt, 256);
		check_count("mem write", mem_cnt, 65536);
	endtask

	task automatic run_evt(input logic [3:0] evt, input logic [7:0] sz, input logic pend);
		@(posedge clk_sys);
		save_evt <= evt;
		@(posedge clk_sys);
		save_evt <= '0;
		tick(3);
		check_sz(gba_save_top_i.save_sz, sz);
		check_flag("bk_pending", bk_pending, pend);
	endtask

	task automatic run_img(input logic [31:0] size, input logic [7:0] sz, input logic ena);
		@(posedge clk_sys);
		img <= '{mounted: 1'b1, readonly: 1'b0, size: 64'(size)};
		tick(4);
		check_sz(gba_save_top_i.save_sz, sz);
		check_flag("bk_ena", bk_ena, ena);
	endtask

	task automatic run_save(input logic [7:0] sz, input logic pend);
		exp_load = 1'b0;
		mem_cnt  = 0;
		sd_cnt   = 0;
		@(posedge clk_sys);
		save_req <= 1'b1;
		wait_backup();
		@(posedge clk_sys);
		save_req <= 1'b0;
		tick(2);
		check_count("sd write", sd_cnt, int'(sz) + 1);
		check_count("mem read", mem_cnt, (int'(sz) + 1) * 256);
		check_flag("bk_pending", bk_pending, pend);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin : main
		dl           = '0;
		save_evt     = '0;
		img          = '0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		mem_ack      = 1'b0;
		mem_rdata    = '0;
		exp_load     = 1'b1;
		mem_cnt      = 0;
		sd_cnt       = 0;
		for (int i = 0; i < 65536; i++) begin
			mem_model[i] = 16'(i) ^ 16'h3C5A;
			sd_img[i]    = 16'(i * 40503) ^ 16'hA55A;   // Scrambled by full address
		end
		wait (arst_n);
		tick(2);
		check_flag("bk_busy", bk_busy, 1'b0);   // Quiet after reset
		check_flag("flash_1m", flash_1m, 1'b0);
		check_flag("bios.wr", bios.wr, 1'b0);
		for (int i = 0; i < n_steps; i++) begin
			case (steps[i].op)
				op_bios: run_bios(steps[i].arg[26:0]);
				op_cart: run_cart(steps[i].arg[26:0], steps[i].marker, steps[i].exp_sz);
				op_evt:  run_evt(steps[i].arg[3:0], steps[i].exp_sz, steps[i].exp_flag);
				op_img:  run_img(steps[i].arg, steps[i].exp_sz, steps[i].exp_flag);
				op_save: run_save(steps[i].exp_sz, steps[i].exp_flag);
				default: abort_run("unknown step kind in the table");
			endcase
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* verilog/backup_ctrl.sv */
`timescale 1ns/1ps

module backup_ctrl
	import gba_save_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       load_req,
	input  logic       save_req,
	input  logic       cart_done,
	input  logic       bk_ena,
	input  logic       bk_pending,
	input  logic [7:0] save_sz,
	input  logic       sd_ack,
	input  logic       copy_done,
	output sd_req_t    sd,
	output logic       copy_start,
	output logic       loading,
	output logic       bk_busy
);

	// Same three steps, read in a different order for load and save
	typedef enum logic [1:0] {
		step_begin,
		step_hold,
		step_finish
	} step_t;

	step_t            step;
	logic             load_d;
	logic             save_d;
	logic             ack_d;
	logic             load_rise;
	logic             save_rise;
	logic             ack_rise;
	logic             ack_fall;
	logic             sd_rd;
	logic             sd_wr;
	logic [lba_w-1:0] lba;

	assign load_rise = load_req & ~load_d & bk_ena;
	assign save_rise = save_req & ~save_d & bk_ena & bk_pending;   // Nothing to save otherwise
	assign ack_rise  = sd_ack & ~ack_d;
	assign ack_fall  = ack_d & ~sd_ack;   // Sector finished

	assign sd = '{rd: sd_rd, wr: sd_wr, lba: lba};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			step       <= step_begin;
			load_d     <= 1'b0;
			save_d     <= 1'b0;
			ack_d      <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			lba        <= '0;
			copy_start <= 1'b0;
			loading    <= 1'b0;
			bk_busy    <= 1'b0;
		end else begin
			load_d <= load_req;
			save_d <= save_req;
			ack_d  <= sd_ack;

			// Request held until the SD side takes it
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			// ============================================================
			// Idle
			// ============================================================
			if (!bk_busy) begin
				copy_start <= 1'b0;
				step       <= step_begin;
				lba        <= '0;
				loading    <= load_rise | cart_done;   // Auto load after each cart
				if (load_rise | save_rise | cart_done) bk_busy <= 1'b1;

			// ============================================================
			// Load: SD read, then copy buffer to memory
			// ============================================================
			end else if (loading) begin
				case (step)
					step_begin: begin
						sd_rd <= 1'b1;
						step  <= step_hold;
					end
					step_hold: if (ack_fall) begin
						copy_start <= 1'b1;
						step       <= step_finish;
					end
					step_finish: if (copy_done) begin
						copy_start <= 1'b0;
						step       <= step_begin;
						lba        <= lba + 1'b1;
						if (&lba) bk_busy <= 1'b0;   // Always the full 256 sectors
					end
					default: step <= step_begin;
				endcase

			// Save: copy memory to buffer, then SD write
			end else begin
				case (step)
					step_begin: begin
						copy_start <= 1'b1;
						step       <= step_hold;
					end
					step_hold: if (copy_done) begin
						copy_start <= 1'b0;
						sd_wr      <= 1'b1;
						step       <= step_finish;
					end
					step_finish: if (ack_fall) begin
						step <= step_begin;
						lba  <= lba + 1'b1;
						if (lba == save_sz) bk_busy <= 1'b0;   // Only the used part
					end
					default: step <= step_begin;
				endcase
			end
		end
	end

endmodule

/* verilog/block_copier.sv */
`timescale 1ns/1ps

module block_copier
	import gba_save_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  copy_start,
	input  logic                  loading,
	input  logic                  mem_ack,
	input  logic [lba_w-1:0]      lba,
	input  logic [15:0]           buf_rdata,
	output mem_req_t              mem,
	output logic [buf_addr_w-1:0] buf_addr,
	output logic                  copy_done
);

	logic req;
	logic wait_ack;   // Request out, ack not yet seen

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			req       <= 1'b0;
			wait_ack  <= 1'b0;
			buf_addr  <= '0;
			copy_done <= 1'b0;
		end else begin
			req <= 1'b0;   // Single-cycle pulse
			if (!copy_start) begin
				wait_ack  <= 1'b0;
				buf_addr  <= '0;
				copy_done <= 1'b0;
			end else if (!copy_done) begin
				if (!wait_ack) begin
					req      <= 1'b1;
					wait_ack <= 1'b1;
				end else if (mem_ack) begin   // Memory may stall any number of cycles
					wait_ack <= 1'b0;
					if (&buf_addr) copy_done <= 1'b1;
					else           buf_addr  <= buf_addr + 1'b1;
				end
			end
		end
	end

	// Buffer read data is valid by the time req goes out
	assign mem = '{req: req, rnw: ~loading, addr: {lba, buf_addr}, wdata: buf_rdata};

endmodule

/* verilog/cart_loader.sv */
`timescale 1ns/1ps

module cart_loader
	import gba_save_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  dl_port_t    dl,
	output bios_wr_t    bios,
	output logic        cart_busy,
	output logic        cart_done,
	output logic [24:0] max_pak_addr,
	output logic        flash_1m
);

	logic                   bios_busy;     // BIOS class, registered
	logic                   cart_busy_d;   // For edge detection
	logic                   cart_wr;
	logic [dl_addr_w-1:0]   last_addr;
	logic [63:0]            history;       // Last eight cart bytes
	logic                   bios_wr;
	logic [bios_addr_w-1:0] bios_addr;
	logic [31:0]            bios_data;

	// ============================================================
	// Download class
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bios_busy   <= 1'b0;
			cart_busy   <= 1'b0;
			cart_busy_d <= 1'b0;
		end else begin
			bios_busy   <= dl.download & (dl.index == bios_index);
			cart_busy   <= dl.download & ~&dl.index & (dl.index != bios_index);
			cart_busy_d <= cart_busy;
		end
	end

	assign cart_done = cart_busy_d & ~cart_busy;   // Falling edge of cart_busy
	assign cart_wr   = cart_busy & dl.wr;

	// Address still holds the last written byte when the download ends
	always_ff @(posedge clk_sys) begin
		if (cart_done) last_addr <= dl.addr;
	end

	assign max_pak_addr = last_addr[26:2];   // Word address for the core

	// ============================================================
	// FLASH1M_V search
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			flash_1m <= 1'b0;
			history  <= '0;
		end else begin
			if (cart_busy & ~cart_busy_d) begin
				flash_1m <= 1'b0;   // New cart, forget the old marker
				history  <= '0;
			end else if (cart_wr) begin
				// Marker may end on either byte of the halfword
				if ({history, dl.dout.bytes.lo_byte} == flash_marker) flash_1m <= 1'b1;
				if ({history[55:0], dl.dout.bytes.lo_byte, dl.dout.bytes.hi_byte}
						== flash_marker) flash_1m <= 1'b1;
				history <= {history[47:0], dl.dout.bytes.lo_byte, dl.dout.bytes.hi_byte};
			end
		end
	end

	// ============================================================
	// BIOS word assembly
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) bios_wr <= 1'b0;
		else         bios_wr <= bios_busy & dl.wr & dl.addr[1];   // Upper half completes a word
	end

	always_ff @(posedge clk_sys) begin
		if (bios_busy & dl.wr) begin
			if (!dl.addr[1]) begin
				bios_data[15:0] <= dl.dout.half;
			end else begin
				bios_data[31:16] <= dl.dout.half;
				bios_addr        <= dl.addr[13:2];
			end
		end
	end

	assign bios = '{wr: bios_wr, addr: bios_addr, data: bios_data};

endmodule

/* verilog/gba_save_pkg.sv */
package gba_save_pkg;

	// ============================================================
	// Widths and constants
	// ============================================================
	localparam int dl_addr_w   = 27;   // Download byte address
	localparam int bios_addr_w = 12;   // BIOS 32-bit word address
	localparam int buf_addr_w  = 8;    // 256 halfwords per sector
	localparam int lba_w       = 8;    // Up to 256 sectors of backup

	localparam logic [7:0] bios_index = 8'd0;   // All ones is the code class, dropped here

	// Save size masks, in sectors minus one
	localparam logic [7:0] sz_eeprom = 8'h0F;
	localparam logic [7:0] sz_sram   = 8'h3F;
	localparam logic [7:0] sz_flash  = 8'h7F;   // Bit 7 comes from the 1M marker

	localparam logic [71:0] flash_marker = "FLASH1M_V";

	// ============================================================
	// Types
	// ============================================================

	// One download word, seen as a BIOS halfword or as two cart bytes
	typedef union packed {
		logic [15:0] half;
		struct packed {
			logic [7:0] hi_byte;
			logic [7:0] lo_byte;
		} bytes;
	} dl_word_t;

	typedef struct packed {
		logic                 download;
		logic [7:0]           index;
		logic [dl_addr_w-1:0] addr;
		logic                 wr;
		dl_word_t             dout;
	} dl_port_t;

	typedef struct packed {
		logic                   wr;
		logic [bios_addr_w-1:0] addr;
		logic [31:0]            data;
	} bios_wr_t;

	typedef struct packed {
		logic bus_req;
		logic eeprom;
		logic sram;
		logic flash;
	} save_evt_t;

	typedef struct packed {
		logic        mounted;
		logic        readonly;
		logic [63:0] size;    // Bytes
	} img_t;

	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [lba_w-1:0] lba;
	} sd_req_t;

	typedef struct packed {
		logic                          req;     // One cycle per word
		logic                          rnw;     // High on save
		logic [lba_w+buf_addr_w-1:0]   addr;    // {lba, word}
		logic [15:0]                   wdata;
	} mem_req_t;

endpackage

/* verilog/gba_save_top.sv */
`timescale 1ns/1ps

module gba_save_top
	import gba_save_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  dl_port_t              dl,
	input  save_evt_t             save_evt,
	input  img_t                  img,
	input  logic                  load_req,
	input  logic                  save_req,
	input  logic                  sd_ack,
	input  logic [buf_addr_w-1:0] sd_buff_addr,
	input  logic                  sd_buff_wr,
	input  logic [15:0]           sd_buff_dout,
	output logic [15:0]           sd_buff_din,
	input  logic                  mem_ack,
	input  logic [15:0]           mem_rdata,
	output bios_wr_t              bios,
	output logic [24:0]           max_pak_addr,
	output logic                  flash_1m,
	output logic                  cart_busy,
	output logic                  bk_ena,
	output logic                  bk_pending,
	output logic                  bk_busy,
	output sd_req_t               sd,
	output mem_req_t              mem
);

	logic                  cart_done;
	logic [7:0]            save_sz;
	logic                  copy_start;
	logic                  copy_done;
	logic                  loading;
	logic [buf_addr_w-1:0] buf_addr;
	logic [15:0]           buf_rdata;
	logic                  buf_wr;

	assign buf_wr = mem_ack & ~loading;   // Save direction, memory data into the buffer

	// ============================================================
	// Download side
	// ============================================================
	cart_loader cart_loader_i (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.bios         (bios),
		.cart_busy    (cart_busy),
		.cart_done    (cart_done),
		.max_pak_addr (max_pak_addr),
		.flash_1m     (flash_1m)
	);

	save_tracker save_tracker_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.save_evt   (save_evt),
		.flash_1m   (flash_1m),
		.cart_busy  (cart_busy),
		.bk_busy    (bk_busy),
		.img        (img),
		.save_sz    (save_sz),
		.bk_ena     (bk_ena),
		.bk_pending (bk_pending)
	);

	// ============================================================
	// Backup transfer
	// ============================================================
	backup_ctrl backup_ctrl_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.load_req   (load_req),
		.save_req   (save_req),
		.cart_done  (cart_done),
		.bk_ena     (bk_ena),
		.bk_pending (bk_pending),
		.save_sz    (save_sz),
		.sd_ack     (sd_ack),
		.copy_done  (copy_done),
		.sd         (sd),
		.copy_start (copy_start),
		.loading    (loading),
		.bk_busy    (bk_busy)
	);

	block_copier block_copier_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.copy_start (copy_start),
		.loading    (loading),
		.mem_ack    (mem_ack),
		.lba        (sd.lba),
		.buf_rdata  (buf_rdata),
		.mem        (mem),
		.buf_addr   (buf_addr),
		.copy_done  (copy_done)
	);

	sector_buffer sector_buffer_i (
		.clk_sys (clk_sys),
		.a_addr  (buf_addr),
		.a_wr    (buf_wr),
		.a_wdata (mem_rdata),
		.a_rdata (buf_rdata),
		.b_addr  (sd_buff_addr),
		.b_wr    (sd_buff_wr),
		.b_wdata (sd_buff_dout),
		.b_rdata (sd_buff_din)
	);

endmodule

/* verilog/save_tracker.sv */
`timescale 1ns/1ps

module save_tracker
	import gba_save_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  save_evt_t  save_evt,
	input  logic       flash_1m,
	input  logic       cart_busy,
	input  logic       bk_busy,
	input  img_t       img,
	output logic [7:0] save_sz,
	output logic       bk_ena,
	output logic       bk_pending
);

	logic       cart_busy_d;
	logic       use_img;     // Image size overrides the strobes
	logic       save_hit;
	logic [7:0] evt_mask;

	assign save_hit = save_evt.bus_req & (save_evt.eeprom | save_evt.sram | save_evt.flash);

	// Mask widened by whichever save types this access touched
	always_comb begin
		evt_mask = '0;
		if (save_evt.eeprom) evt_mask = evt_mask | sz_eeprom;
		if (save_evt.sram)   evt_mask = evt_mask | sz_sram;
		if (save_evt.flash)  evt_mask = evt_mask | sz_flash | {flash_1m, 7'd0};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_busy_d <= 1'b0;
			use_img     <= 1'b0;
			save_sz     <= '0;
			bk_ena      <= 1'b0;
			bk_pending  <= 1'b0;
		end else begin
			cart_busy_d <= cart_busy;

			if (cart_busy & ~cart_busy_d) begin
				use_img <= 1'b0;   // Fresh cart
				save_sz <= '0;
			end else if (img.mounted && |img.size && !img.readonly) begin
				use_img <= 1'b1;
				save_sz <= img.size[16:9] - 8'd1;   // 512-byte sectors
			end else if (save_evt.bus_req & ~use_img) begin
				save_sz <= save_sz | evt_mask;
			end

			bk_ena <= |save_sz;

			if (save_hit)     bk_pending <= 1'b1;
			else if (bk_busy) bk_pending <= 1'b0;   // Cleared by any load or save
		end
	end

endmodule

/* verilog/sector_buffer.sv */
`timescale 1ns/1ps

module sector_buffer
	import gba_save_pkg::*;
(
	input  logic                  clk_sys,
	input  logic [buf_addr_w-1:0] a_addr,
	input  logic                  a_wr,
	input  logic [15:0]           a_wdata,
	output logic [15:0]           a_rdata,
	input  logic [buf_addr_w-1:0] b_addr,
	input  logic                  b_wr,
	input  logic [15:0]           b_wdata,
	output logic [15:0]           b_rdata
);

	logic [15:0] ram [0:(1<<buf_addr_w)-1];   // One SD sector

	// Port A on the memory side, port B on the SD side
	always_ff @(posedge clk_sys) begin
		if (a_wr) ram[a_addr] <= a_wdata;
		if (b_wr) ram[b_addr] <= b_wdata;
		a_rdata <= ram[a_addr];   // Registered reads on both ports
		b_rdata <= ram[b_addr];
	end

endmodule
